//--- dv/sfu_div_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "sfu_settings.svh"

module sfu_div_tb;

  localparam int XLEN         = `SFU_XLEN;
  localparam int NUM_THREAD   = `SFU_NUM_THREAD;
  localparam int NUM_LANE     = `SFU_NUM_LANE;
  localparam int NUM_GRP      = `SFU_NUM_GRP;
  localparam int NUM_INSTR    = 18;
  localparam int STALL_CYCLES = 60;
  // each instruction may take every group at double the divider time
  localparam int TIMEOUT_CYCLES = NUM_INSTR * NUM_GRP * (XLEN + 10) * 2 + STALL_CYCLES;
  localparam sfu_pkg::lane_word_t MIN_VAL = {1'b1, {(XLEN-1){1'b0}}};

  logic clk;
  logic rst_n;
  logic in_valid_i, in_ready_o, in_reverse_i, in_isvec_i, in_wxd_i, in_wvd_i;
  sfu_pkg::warp_data_t   in_src1_i, in_src2_i, out_v_wb_wvd_rd_o;
  sfu_pkg::thread_mask_t in_mask_i, out_v_wvd_mask_o;
  sfu_pkg::warp_id_t     in_wid_i, out_x_warp_id_o, out_v_warp_id_o;
  sfu_pkg::div_op_e      in_op_i;
  sfu_pkg::reg_idx_t     in_reg_idxw_i, out_x_reg_idxw_o, out_v_reg_idxw_o;
  logic out_x_valid_o, out_x_ready_i, out_x_wxd_o, out_v_valid_o, out_v_ready_i, out_v_wvd_o;
  sfu_pkg::lane_word_t   out_x_wb_wxd_rd_o;

  int          cycle_cnt = 0;
  int          err_cnt = 0;
  int          test_err = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  logic [31:0] rng_state = 32'd41;
  string       cur_test = "reset";

  sfu_div_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles in test %s", cycle_cnt, cur_test);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  function automatic sfu_pkg::lane_word_t xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic sfu_pkg::warp_data_t random_warp(input int shift_step);
    sfu_pkg::warp_data_t w;
    for (int t = 0; t < NUM_THREAD; t++) begin
      w[t] = xorshift() >> (t * shift_step);
    end
    return w;
  endfunction

  // RISC-V divide rules including zero divisor and signed overflow
  function automatic sfu_pkg::lane_word_t lane_model(input sfu_pkg::div_op_e op,
                                                     input sfu_pkg::lane_word_t a,
                                                     input sfu_pkg::lane_word_t b);
    logic is_rem;
    logic is_uns;
    is_rem = op inside {sfu_pkg::OP_REM, sfu_pkg::OP_REMU};
    is_uns = op inside {sfu_pkg::OP_DIVU, sfu_pkg::OP_REMU};
    if (b == '0) return is_rem ? a : '1;
    if (!is_uns && a == MIN_VAL && b == '1) return is_rem ? '0 : a;
    if (is_uns) return is_rem ? a % b : a / b;
    return is_rem ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
  endfunction

  // groups without an active lane stay zero, active groups fill all lanes
  function automatic sfu_pkg::warp_data_t warp_model(input sfu_pkg::div_op_e op,
      input sfu_pkg::warp_data_t s1, input sfu_pkg::warp_data_t s2,
      input sfu_pkg::thread_mask_t mask, input logic rev);
    sfu_pkg::warp_data_t w;
    w = '0;
    for (int g = 0; g < NUM_GRP; g++) begin
      if (|mask[g*NUM_LANE +: NUM_LANE]) begin
        for (int l = g * NUM_LANE; l < (g + 1) * NUM_LANE; l++) begin
          w[l] = rev ? lane_model(op, s2[l], s1[l]) : lane_model(op, s1[l], s2[l]);
        end
      end
    end
    return w;
  endfunction

  task automatic check_word(input string name, input sfu_pkg::lane_word_t got,
                            input sfu_pkg::lane_word_t exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_warp(input string name, input sfu_pkg::warp_data_t got,
                            input sfu_pkg::warp_data_t exp);
    for (int t = 0; t < NUM_THREAD; t++) begin
      if (got[t] !== exp[t]) begin
        $display("[ERROR] %s[%0d]: got %h expected %h", name, t, got[t], exp[t]);
        err_cnt++;
      end
    end
  endtask

  task automatic check_meta(input string name, input sfu_pkg::warp_id_t wid,
      input sfu_pkg::reg_idx_t ridx, input sfu_pkg::thread_mask_t mask,
      input sfu_pkg::warp_id_t exp_wid, input sfu_pkg::reg_idx_t exp_ridx,
      input sfu_pkg::thread_mask_t exp_mask);
    if (wid !== exp_wid || ridx !== exp_ridx || mask !== exp_mask) begin
      $display("[ERROR] %s warp_id/reg_idxw/mask: got %h/%h/%h expected %h/%h/%h",
               name, wid, ridx, mask, exp_wid, exp_ridx, exp_mask);
      err_cnt++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got %h expected %h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    test_err = err_cnt;
  endtask

  task automatic end_test();
    tests_run++;
    if (err_cnt == test_err) begin
      $display("test %s: ok", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", cur_test, err_cnt - test_err);
    end
  endtask

  // called and left 1 ns after a rising edge
  task automatic send_instr(input sfu_pkg::div_op_e op, input sfu_pkg::warp_data_t s1,
      input sfu_pkg::warp_data_t s2, input sfu_pkg::thread_mask_t mask, input logic isvec,
      input logic rev, input logic wxd, input logic wvd, input sfu_pkg::warp_id_t wid,
      input sfu_pkg::reg_idx_t ridx);
    in_op_i = op;
    in_src1_i = s1;
    in_src2_i = s2;
    in_mask_i = mask;
    in_isvec_i = isvec;
    in_reverse_i = rev;
    in_wxd_i = wxd;
    in_wvd_i = wvd;
    in_wid_i = wid;
    in_reg_idxw_i = ridx;
    in_valid_i = 1'b1;
    @(negedge clk);
    while (!in_ready_o) @(negedge clk);
    @(posedge clk);
    #1;
    in_valid_i = 1'b0;
  endtask

  task automatic run_scalar(input sfu_pkg::div_op_e op, input sfu_pkg::lane_word_t a,
                            input sfu_pkg::lane_word_t b, input logic rev);
    sfu_pkg::warp_data_t s1;
    sfu_pkg::warp_data_t s2;
    sfu_pkg::warp_id_t   wid;
    sfu_pkg::reg_idx_t   ridx;
    s1 = random_warp(0);
    s2 = random_warp(0);
    s1[0] = a;
    s2[0] = b;
    wid = sfu_pkg::warp_id_t'(xorshift());
    ridx = sfu_pkg::reg_idx_t'(xorshift());
    // the mask is random since a scalar instruction ignores it
    send_instr(op, s1, s2, sfu_pkg::thread_mask_t'(xorshift()), 1'b0, rev, 1'b1, 1'b0,
               wid, ridx);
    @(negedge clk);
    while (!out_x_valid_o) @(negedge clk);
    check_word("out_x_wb_wxd_rd_o", out_x_wb_wxd_rd_o, rev ? lane_model(op, b, a)
                                                           : lane_model(op, a, b));
    check_flag("out_x_wxd_o", out_x_wxd_o, 1'b1);
    check_meta("out_x", out_x_warp_id_o, out_x_reg_idxw_o, '0, wid, ridx, '0);
    @(posedge clk);
    #1;
  endtask

  task automatic run_vector(input sfu_pkg::div_op_e op, input sfu_pkg::thread_mask_t mask,
                            input logic rev);
    sfu_pkg::warp_data_t s1;
    sfu_pkg::warp_data_t s2;
    sfu_pkg::warp_id_t   wid;
    sfu_pkg::reg_idx_t   ridx;
    s1 = random_warp(0);
    s2 = random_warp(3);
    wid = sfu_pkg::warp_id_t'(xorshift());
    ridx = sfu_pkg::reg_idx_t'(xorshift());
    send_instr(op, s1, s2, mask, 1'b1, rev, 1'b0, 1'b1, wid, ridx);
    @(negedge clk);
    while (!out_v_valid_o) @(negedge clk);
    check_warp("out_v_wb_wvd_rd_o", out_v_wb_wvd_rd_o, warp_model(op, s1, s2, mask, rev));
    check_flag("out_v_wvd_o", out_v_wvd_o, 1'b1);
    check_meta("out_v", out_v_warp_id_o, out_v_reg_idxw_o, out_v_wvd_mask_o, wid, ridx, mask);
    @(posedge clk);
    #1;
  endtask

  // wait until the unit is idle again and expect no queued output
  task automatic expect_silent_retire();
    @(negedge clk);
    while (!in_ready_o) @(negedge clk);
    // a queued result would appear together with the return to idle
    if (out_x_valid_o || out_v_valid_o) begin
      $display("an output became valid for an instruction with its write flag clear");
      err_cnt++;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic test_backpressure();
    sfu_pkg::lane_word_t a;
    sfu_pkg::lane_word_t b;
    a = xorshift();
    b = xorshift() >> 4;
    out_x_ready_i = 1'b0;
    out_v_ready_i = 1'b0;
    send_instr(sfu_pkg::OP_DIVU, {NUM_THREAD{a}}, {NUM_THREAD{b}}, '0, 1'b0, 1'b0, 1'b1, 1'b0,
               sfu_pkg::warp_id_t'(1), sfu_pkg::reg_idx_t'(8'h11));
    @(negedge clk);
    while (!out_x_valid_o) @(negedge clk);
    @(posedge clk);
    #1;
    send_instr(sfu_pkg::OP_REM, {NUM_THREAD{b}}, {NUM_THREAD{a >> 20}}, '0, 1'b0, 1'b0, 1'b1,
               1'b0, sfu_pkg::warp_id_t'(2), sfu_pkg::reg_idx_t'(8'h22));
    repeat (STALL_CYCLES) begin
      @(negedge clk);
      if (in_ready_o) begin
        $display("in_ready_o is high while a second instruction is held");
        err_cnt++;
      end
      check_word("out_x_wb_wxd_rd_o", out_x_wb_wxd_rd_o, lane_model(sfu_pkg::OP_DIVU, a, b));
      check_meta("out_x", out_x_warp_id_o, out_x_reg_idxw_o, '0, sfu_pkg::warp_id_t'(1),
                 sfu_pkg::reg_idx_t'(8'h11), '0);
    end
    @(posedge clk);
    #1;
    out_x_ready_i = 1'b1;
    out_v_ready_i = 1'b1;
    // first result drains on this edge and the second one moves in
    @(posedge clk);
    #1;
    @(negedge clk);
    while (!out_x_valid_o) @(negedge clk);
    check_word("out_x_wb_wxd_rd_o", out_x_wb_wxd_rd_o, lane_model(sfu_pkg::OP_REM, b, a >> 20));
    check_meta("out_x", out_x_warp_id_o, out_x_reg_idxw_o, '0, sfu_pkg::warp_id_t'(2),
               sfu_pkg::reg_idx_t'(8'h22), '0);
    @(posedge clk);
    #1;
  endtask

  initial begin
    rst_n = 1'b0;
    in_valid_i = 1'b0;
    in_src1_i = '0;
    in_src2_i = '0;
    in_mask_i = '0;
    in_wid_i = '0;
    in_reverse_i = 1'b0;
    in_isvec_i = 1'b0;
    in_wxd_i = 1'b0;
    in_wvd_i = 1'b0;
    in_op_i = sfu_pkg::OP_DIV;
    in_reg_idxw_i = '0;
    out_x_ready_i = 1'b1;
    out_v_ready_i = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    if (!in_ready_o || out_x_valid_o || out_v_valid_o) begin
      $display("handshake outputs are wrong after reset");
      err_cnt++;
    end

    begin_test("scalar_random");
    for (int i = 0; i < 4; i++) begin
      run_scalar(sfu_pkg::div_op_e'(2'(i)), xorshift(), xorshift() >> 8, 1'b0);
    end
    end_test();

    begin_test("corner_cases");
    run_scalar(sfu_pkg::OP_DIV, xorshift(), '0, 1'b0);
    run_scalar(sfu_pkg::OP_REMU, xorshift(), '0, 1'b0);
    run_scalar(sfu_pkg::OP_DIV, MIN_VAL, '1, 1'b0);
    run_scalar(sfu_pkg::OP_REM, MIN_VAL, '1, 1'b0);
    run_scalar(sfu_pkg::OP_DIVU, 32'd7, 32'd100, 1'b1);
    end_test();

    begin_test("vector_full_mask");
    run_vector(sfu_pkg::OP_REM, '1, 1'b0);
    end_test();

    begin_test("partial_masks");
    run_vector(sfu_pkg::OP_DIV, sfu_pkg::thread_mask_t'(8'hA0), 1'b0);
    run_vector(sfu_pkg::OP_REMU, sfu_pkg::thread_mask_t'(8'h04), 1'b1);
    run_vector(sfu_pkg::OP_DIV, '0, 1'b0);
    end_test();

    begin_test("backpressure");
    test_backpressure();
    end_test();

    begin_test("write_flags_clear");
    send_instr(sfu_pkg::OP_DIV, random_warp(0), random_warp(2), '1, 1'b0, 1'b0, 1'b0, 1'b1,
               sfu_pkg::warp_id_t'(3), sfu_pkg::reg_idx_t'(8'h33));
    expect_silent_retire();
    send_instr(sfu_pkg::OP_REM, random_warp(0), random_warp(2), '1, 1'b1, 1'b0, 1'b1, 1'b0,
               sfu_pkg::warp_id_t'(4), sfu_pkg::reg_idx_t'(8'h44));
    expect_silent_retire();
    run_scalar(sfu_pkg::OP_DIVU, xorshift(), xorshift() >> 16, 1'b0);
    end_test();

    $display("tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+include
verilog/sfu_pkg.sv
verilog/entry_buffer.sv
verilog/group_mask_tracker.sv
verilog/lane_divider.sv
verilog/result_collector.sv
verilog/sfu_ctrl_fsm.sv
verilog/sfu_div_top.sv
dv/sfu_div_tb.sv

//--- include/sfu_settings.svh
`ifndef SFU_SETTINGS_SVH
`define SFU_SETTINGS_SVH

// width of one lane operand
`define SFU_XLEN 32

// lanes carried by one warp instruction
`define SFU_NUM_THREAD 8

// parallel lane dividers serving one thread group per pass
`define SFU_NUM_LANE 4

// thread groups per warp
`define SFU_NUM_GRP (`SFU_NUM_THREAD / `SFU_NUM_LANE)

// warp id width
`define SFU_WARP_W 3

// destination register index including extension bits
`define SFU_REG_W 8

`endif

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module sfu_div_tb -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vsfu_div_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "Simulation finished: PASS"; then
  exit 0
fi
exit 1

//--- verilog/entry_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module entry_buffer #(
  parameter int WIDTH = 8
) (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              wr_valid_i,
  output logic             wr_ready_o,
  input  wire  [WIDTH-1:0] wr_data_i,
  output logic             rd_valid_o,
  input  wire              rd_ready_i,
  output logic [WIDTH-1:0] rd_data_o
);

  logic             full_q;
  logic [WIDTH-1:0] data_q;
  logic             wr_fire;
  logic             rd_fire;

  // a full entry can be replaced in the cycle it drains
  assign wr_ready_o = !full_q || rd_ready_i;
  assign wr_fire    = wr_valid_i && wr_ready_o;
  assign rd_fire    = full_q && rd_ready_i;
  assign rd_valid_o = full_q;
  assign rd_data_o  = data_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (wr_fire) begin
      full_q <= 1'b1;
    end else if (rd_fire) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      data_q <= wr_data_i;
    end
  end

  // a held entry is neither dropped nor overwritten until it is read
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    full_q && !rd_ready_i |=> full_q && $stable(data_q));

endmodule

`default_nettype wire

//--- verilog/group_mask_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "sfu_settings.svh"

module group_mask_tracker (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   load_i,
  input  wire  sfu_pkg::thread_mask_t mask_i,
  input  wire                   grp_done_i,
  output sfu_pkg::group_idx_t   grp_idx_o,
  output logic                  any_active_o
);

  localparam int NUM_GRP  = `SFU_NUM_GRP;
  localparam int NUM_LANE = `SFU_NUM_LANE;

  sfu_pkg::thread_mask_t mask_q;
  logic [NUM_GRP-1:0]    grp_any;

  // one request bit per thread group
  always_comb begin
    for (int g = 0; g < NUM_GRP; g++) begin
      grp_any[g] = |mask_q[g*NUM_LANE +: NUM_LANE];
    end
  end

  // lowest active group wins
  always_comb begin
    grp_idx_o = '0;
    for (int g = NUM_GRP - 1; g >= 0; g--) begin
      if (grp_any[g]) begin
        grp_idx_o = sfu_pkg::group_idx_t'(g);
      end
    end
  end

  assign any_active_o = |grp_any;

  // served groups drop out, which steps the selection forward
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mask_q <= '0;
    end else if (load_i) begin
      mask_q <= mask_i;
    end else if (grp_done_i) begin
      for (int g = 0; g < NUM_GRP; g++) begin
        if (grp_idx_o == sfu_pkg::group_idx_t'(g)) begin
          mask_q[g*NUM_LANE +: NUM_LANE] <= '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/lane_divider.sv
`timescale 1ns/1ps
`default_nettype none

`include "sfu_settings.svh"

module lane_divider (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 start_i,
  input  wire  sfu_pkg::div_op_e op_i,
  input  wire  sfu_pkg::lane_word_t dividend_i,
  input  wire  sfu_pkg::lane_word_t divisor_i,
  output sfu_pkg::lane_word_t result_o,
  output logic                busy_o,
  output logic                done_o
);

  localparam int XLEN  = `SFU_XLEN;
  localparam int CNT_W = $clog2(XLEN + 1);

  logic                is_signed;
  logic                a_neg;
  logic                b_neg;
  sfu_pkg::lane_word_t a_abs;
  sfu_pkg::lane_word_t b_abs;
  logic                busy_q;
  logic [CNT_W-1:0]    cnt_q;
  logic                last_step;
  sfu_pkg::lane_word_t quo_q;
  sfu_pkg::lane_word_t rem_q;
  sfu_pkg::lane_word_t dsr_q;
  logic                neg_quo_q;
  logic                neg_rem_q;
  logic                rem_sel_q;
  logic                div_zero_q;
  logic [XLEN:0]       shifted;
  logic [XLEN:0]       diff;
  sfu_pkg::lane_word_t quo_fix;
  sfu_pkg::lane_word_t rem_fix;

  assign is_signed = (op_i == sfu_pkg::OP_DIV) || (op_i == sfu_pkg::OP_REM);
  assign a_neg     = is_signed && dividend_i[XLEN-1];
  assign b_neg     = is_signed && divisor_i[XLEN-1];
  assign a_abs     = a_neg ? -dividend_i : dividend_i;
  assign b_abs     = b_neg ? -divisor_i : divisor_i;

  assign last_step = (cnt_q == CNT_W'(XLEN));
  assign busy_o    = busy_q;
  assign done_o    = busy_q && last_step;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start_i) begin
      busy_q <= 1'b1;
      cnt_q  <= '0;
    end else if (busy_q) begin
      if (last_step) begin
        busy_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q + CNT_W'(1);
      end
    end
  end

  // restoring shift-subtract with one quotient bit per step
  assign shifted = {rem_q, quo_q[XLEN-1]};
  assign diff    = shifted - {1'b0, dsr_q};

  always_ff @(posedge clk) begin
    if (start_i) begin
      quo_q      <= a_abs;
      rem_q      <= '0;
      dsr_q      <= b_abs;
      neg_quo_q  <= a_neg ^ b_neg;
      neg_rem_q  <= a_neg;
      rem_sel_q  <= (op_i == sfu_pkg::OP_REM) || (op_i == sfu_pkg::OP_REMU);
      div_zero_q <= (divisor_i == '0);
    end else if (busy_q && !last_step) begin
      if (!diff[XLEN]) begin
        rem_q <= diff[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b1};
      end else begin
        rem_q <= shifted[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b0};
      end
    end
  end

  // divide by zero leaves |a| in rem, so only the quotient needs forcing.
  // min / -1 wraps back to the dividend with a zero remainder on its own
  assign quo_fix  = div_zero_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
  assign rem_fix  = neg_rem_q ? -rem_q : rem_q;
  assign result_o = rem_sel_q ? rem_fix : quo_fix;

  a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
    busy_o |-> !start_i);

  // fixed latency the controller counts on
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    start_i |-> ##(XLEN + 1) done_o);

endmodule

`default_nettype wire

//--- verilog/result_collector.sv
`timescale 1ns/1ps
`default_nettype none

`include "sfu_settings.svh"

module result_collector (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   grp_wr_i,
  input  wire  sfu_pkg::group_idx_t grp_idx_i,
  input  wire  sfu_pkg::group_data_t grp_data_i,
  input  wire                   clear_i,
  output sfu_pkg::warp_data_t   warp_data_o
);

  localparam int NUM_GRP  = `SFU_NUM_GRP;
  localparam int NUM_LANE = `SFU_NUM_LANE;

  sfu_pkg::warp_data_t warp_q;

  // unserved groups of a warp read back as zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      warp_q <= '0;
    end else if (clear_i) begin
      warp_q <= '0;
    end else if (grp_wr_i) begin
      for (int g = 0; g < NUM_GRP; g++) begin
        if (grp_idx_i == sfu_pkg::group_idx_t'(g)) begin
          warp_q[g*NUM_LANE +: NUM_LANE] <= grp_data_i;
        end
      end
    end
  end

  assign warp_data_o = warp_q;

endmodule

`default_nettype wire

//--- verilog/sfu_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module sfu_ctrl_fsm (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 in_fire_i,
  input  wire                 is_vec_i,
  input  wire                 wxd_i,
  input  wire                 wvd_i,
  input  wire                 any_active_i,
  input  wire                 lane_busy_i,
  input  wire                 lane_done_i,
  input  wire                 x_ready_i,
  input  wire                 v_ready_i,
  output sfu_pkg::sfu_state_e state_o,
  output logic                load_o,
  output logic                start_o,
  output logic                grp_done_o,
  output logic                x_wr_o,
  output logic                v_wr_o,
  output logic                retire_o
);

  sfu_pkg::sfu_state_e state_q;
  sfu_pkg::sfu_state_e state_d;
  logic                want_x;
  logic                want_v;

  // scalar results go to x, vector results to v
  assign want_x = !is_vec_i && wxd_i;
  assign want_v = is_vec_i && wvd_i;

  assign load_o     = (state_q == sfu_pkg::S_IDLE) && in_fire_i;
  assign start_o    = (state_q == sfu_pkg::S_BUSY) && any_active_i && !lane_busy_i;
  assign grp_done_o = (state_q == sfu_pkg::S_BUSY) && lane_done_i;

  // write only into a queue that can take it
  assign x_wr_o   = (state_q == sfu_pkg::S_FINISH) && want_x && x_ready_i;
  assign v_wr_o   = (state_q == sfu_pkg::S_FINISH) && want_v && v_ready_i;
  assign retire_o = (state_q == sfu_pkg::S_FINISH) &&
                    (x_wr_o || v_wr_o || !(want_x || want_v));
  assign state_o  = state_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      sfu_pkg::S_IDLE: begin
        if (in_fire_i) begin
          state_d = sfu_pkg::S_BUSY;
        end
      end
      sfu_pkg::S_BUSY: begin
        if (!any_active_i) begin
          state_d = sfu_pkg::S_FINISH;
        end
      end
      sfu_pkg::S_FINISH: begin
        if (retire_o) begin
          state_d = sfu_pkg::S_IDLE;
        end
      end
      default: begin
        state_d = sfu_pkg::S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= sfu_pkg::S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // a group in flight keeps the unit busy until its result is taken
  a_busy_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == sfu_pkg::S_BUSY) && lane_busy_i |=> state_q == sfu_pkg::S_BUSY);

  // the held instruction picks the single write of a finish
  a_flags_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q == sfu_pkg::S_FINISH) && !retire_o |=> $stable({is_vec_i, wxd_i, wvd_i}));

endmodule

`default_nettype wire

//--- verilog/sfu_div_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sfu_settings.svh"

module sfu_div_top (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   in_valid_i,
  output logic                  in_ready_o,
  input  wire  sfu_pkg::warp_data_t in_src1_i,
  input  wire  sfu_pkg::warp_data_t in_src2_i,
  input  wire  sfu_pkg::thread_mask_t in_mask_i,
  input  wire  sfu_pkg::warp_id_t in_wid_i,
  input  wire                   in_reverse_i,
  input  wire                   in_isvec_i,
  input  wire                   in_wxd_i,
  input  wire                   in_wvd_i,
  input  wire  sfu_pkg::div_op_e in_op_i,
  input  wire  sfu_pkg::reg_idx_t in_reg_idxw_i,
  output logic                  out_x_valid_o,
  input  wire                   out_x_ready_i,
  output sfu_pkg::warp_id_t     out_x_warp_id_o,
  output logic                  out_x_wxd_o,
  output sfu_pkg::reg_idx_t     out_x_reg_idxw_o,
  output sfu_pkg::lane_word_t   out_x_wb_wxd_rd_o,
  output logic                  out_v_valid_o,
  input  wire                   out_v_ready_i,
  output sfu_pkg::warp_id_t     out_v_warp_id_o,
  output logic                  out_v_wvd_o,
  output sfu_pkg::reg_idx_t     out_v_reg_idxw_o,
  output sfu_pkg::thread_mask_t out_v_wvd_mask_o,
  output sfu_pkg::warp_data_t   out_v_wb_wvd_rd_o
);

  localparam int NUM_LANE = `SFU_NUM_LANE;
  localparam int META_W   = $bits(sfu_pkg::warp_id_t) + $bits(sfu_pkg::reg_idx_t);
  localparam int IN_W     = 2 * $bits(sfu_pkg::warp_data_t) + $bits(sfu_pkg::thread_mask_t) +
                            META_W + 6;
  localparam int X_W      = META_W + $bits(sfu_pkg::lane_word_t);
  localparam int V_W      = META_W + $bits(sfu_pkg::thread_mask_t) + $bits(sfu_pkg::warp_data_t);

  logic                  is_idle;
  logic                  in_buf_wr_ready;
  logic                  in_fire;
  logic [IN_W-1:0]       in_buf_data;
  sfu_pkg::warp_data_t   b_src1;
  sfu_pkg::warp_data_t   b_src2;
  sfu_pkg::thread_mask_t b_mask;
  sfu_pkg::warp_id_t     b_wid;
  sfu_pkg::reg_idx_t     b_reg;
  logic                  b_reverse;
  logic                  b_isvec;
  logic                  b_wxd;
  logic                  b_wvd;
  logic [1:0]            b_op;
  sfu_pkg::thread_mask_t load_mask;
  sfu_pkg::sfu_state_e   state;
  logic                  load;
  logic                  start;
  logic                  grp_done;
  logic                  x_wr;
  logic                  v_wr;
  logic                  retire;
  logic                  x_ready;
  logic                  v_ready;
  logic                  any_active;
  sfu_pkg::group_idx_t   grp_idx;
  sfu_pkg::group_data_t  src1_grp;
  sfu_pkg::group_data_t  src2_grp;
  sfu_pkg::group_data_t  grp_a;
  sfu_pkg::group_data_t  grp_b;
  sfu_pkg::group_data_t  grp_res;
  logic [NUM_LANE-1:0]   lane_busy;
  logic [NUM_LANE-1:0]   lane_done;
  sfu_pkg::warp_data_t   warp_data;
  logic [X_W-1:0]        x_q_data;
  logic [V_W-1:0]        v_q_data;

  // new work is taken only while the controller is idle
  assign is_idle    = (state == sfu_pkg::S_IDLE);
  assign in_ready_o = in_buf_wr_ready && is_idle;
  assign in_fire    = in_valid_i && in_ready_o;

  entry_buffer #(.WIDTH(IN_W)) u_in_buf (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_valid_i (in_valid_i && is_idle),
    .wr_ready_o (in_buf_wr_ready),
    .wr_data_i  ({in_src1_i, in_src2_i, in_mask_i, in_wid_i, in_reverse_i, in_isvec_i,
                  in_wxd_i, in_wvd_i, in_op_i, in_reg_idxw_i}),
    .rd_valid_o (),
    .rd_ready_i (retire),
    .rd_data_o  (in_buf_data)
  );

  assign {b_src1, b_src2, b_mask, b_wid, b_reverse, b_isvec, b_wxd, b_wvd, b_op, b_reg} =
    in_buf_data;

  // a scalar instruction always runs lane 0 of group 0
  assign load_mask = in_isvec_i ? in_mask_i : sfu_pkg::thread_mask_t'(1);

  group_mask_tracker u_tracker (
    .clk          (clk),
    .rst_n        (rst_n),
    .load_i       (load),
    .mask_i       (load_mask),
    .grp_done_i   (grp_done),
    .grp_idx_o    (grp_idx),
    .any_active_o (any_active)
  );

  assign src1_grp = b_src1[grp_idx*NUM_LANE +: NUM_LANE];
  assign src2_grp = b_src2[grp_idx*NUM_LANE +: NUM_LANE];
  assign grp_a    = b_reverse ? src2_grp : src1_grp;
  assign grp_b    = b_reverse ? src1_grp : src2_grp;

  for (genvar l = 0; l < NUM_LANE; l++) begin : g_lane
    lane_divider u_div (
      .clk        (clk),
      .rst_n      (rst_n),
      .start_i    (start),
      .op_i       (sfu_pkg::div_op_e'(b_op)),
      .dividend_i (grp_a[l]),
      .divisor_i  (grp_b[l]),
      .result_o   (grp_res[l]),
      .busy_o     (lane_busy[l]),
      .done_o     (lane_done[l])
    );
  end

  result_collector u_collect (
    .clk         (clk),
    .rst_n       (rst_n),
    .grp_wr_i    (grp_done),
    .grp_idx_i   (grp_idx),
    .grp_data_i  (grp_res),
    .clear_i     (retire),
    .warp_data_o (warp_data)
  );

  sfu_ctrl_fsm u_fsm (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_fire_i    (in_fire),
    .is_vec_i     (b_isvec),
    .wxd_i        (b_wxd),
    .wvd_i        (b_wvd),
    .any_active_i (any_active),
    .lane_busy_i  (|lane_busy),
    .lane_done_i  (&lane_done),
    .x_ready_i    (x_ready),
    .v_ready_i    (v_ready),
    .state_o      (state),
    .load_o       (load),
    .start_o      (start),
    .grp_done_o   (grp_done),
    .x_wr_o       (x_wr),
    .v_wr_o       (v_wr),
    .retire_o     (retire)
  );

  entry_buffer #(.WIDTH(X_W)) u_x_q (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_valid_i (x_wr),
    .wr_ready_o (x_ready),
    .wr_data_i  ({b_wid, b_reg, warp_data[0]}),
    .rd_valid_o (out_x_valid_o),
    .rd_ready_i (out_x_ready_i),
    .rd_data_o  (x_q_data)
  );

  entry_buffer #(.WIDTH(V_W)) u_v_q (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_valid_i (v_wr),
    .wr_ready_o (v_ready),
    .wr_data_i  ({b_wid, b_reg, b_mask, warp_data}),
    .rd_valid_o (out_v_valid_o),
    .rd_ready_i (out_v_ready_i),
    .rd_data_o  (v_q_data)
  );

  assign {out_x_warp_id_o, out_x_reg_idxw_o, out_x_wb_wxd_rd_o} = x_q_data;
  assign {out_v_warp_id_o, out_v_reg_idxw_o, out_v_wvd_mask_o, out_v_wb_wvd_rd_o} = v_q_data;

  // only flagged results are queued, so the flag follows valid
  assign out_x_wxd_o = out_x_valid_o;
  assign out_v_wvd_o = out_v_valid_o;

endmodule

`default_nettype wire

//--- verilog/sfu_pkg.sv
`default_nettype none

`include "sfu_settings.svh"

package sfu_pkg;

  localparam int GRP_IDX_W = ($clog2(`SFU_NUM_GRP) > 0) ? $clog2(`SFU_NUM_GRP) : 1;

  typedef enum logic [1:0] {
    S_IDLE   = 2'd0,
    S_BUSY   = 2'd1,
    S_FINISH = 2'd2
  } sfu_state_e;

  // bit 0 picks the remainder, bit 1 picks unsigned
  typedef enum logic [1:0] {
    OP_DIV  = 2'b00,
    OP_DIVU = 2'b10,
    OP_REM  = 2'b01,
    OP_REMU = 2'b11
  } div_op_e;

  typedef logic [`SFU_XLEN-1:0]       lane_word_t;
  typedef logic [`SFU_NUM_THREAD-1:0] thread_mask_t;
  typedef logic [GRP_IDX_W-1:0]       group_idx_t;
  typedef logic [`SFU_WARP_W-1:0]     warp_id_t;
  typedef logic [`SFU_REG_W-1:0]      reg_idx_t;

  typedef logic [`SFU_NUM_THREAD-1:0][`SFU_XLEN-1:0] warp_data_t;
  typedef logic [`SFU_NUM_LANE-1:0][`SFU_XLEN-1:0]   group_data_t;

endpackage

`default_nettype wire
